// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module mem_port_tb -o mem_port_sim

output=$(./obj_dir/mem_port_sim)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi

// File: sources.f
+incdir+src
src/mem_port_pkg.sv
src/core_mem_ctrl.sv
src/mem_bus_switch.sv
src/fetch_unit.sv
src/mem_port_top.sv
verification/clock_gen.sv
verification/mem_port_tb.sv

// File: src/core_mem_ctrl.sv
`timescale 1ns/1ps

module core_mem_ctrl (
    input  logic                        clock,
    input  logic                        reset,
    input  mem_port_pkg::bus_cmd_e      dcache_command,
    input  logic                        dispatch_ok,
    input  logic                        halt,
    input  logic                        halt_confirm,
    input  logic                        illegal,
    input  logic                        flush,
    output logic                        data_owns_bus,
    output logic                        route_to_data,
    output logic                        route_to_fetch,
    output logic                        fetch_enable,
    output logic                        fetch_flush,
    output mem_port_pkg::error_status_e error_status
);
    import mem_port_pkg::*;

    //////////////////////////////
    // ownership history
    //////////////////////////////

    // bit 0 is the current owner, bit 2 the owner two cycles back
    logic [2:0] own_hist;
    logic       data_req;

    // any data command claims the bus for the next cycle
    assign data_req = (dcache_command != bus_none);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            own_hist <= '0;
        end else begin
            own_hist <= {own_hist[1:0], data_req};
        end
    end

    assign data_owns_bus = own_hist[0];

    // response goes to whoever held the bus both now and two cycles ago
    // a mixed history drops the response on the floor
    assign route_to_data  = own_hist[0] & own_hist[2];
    assign route_to_fetch = ~own_hist[0] & ~own_hist[2];

    //////////////////////////////
    // halt latch
    //////////////////////////////

    logic halt_latch;

    // sticky until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halt_latch <= 1'b0;
        end else if (halt) begin
            halt_latch <= 1'b1;
        end
    end

    //////////////////////////////
    // fetch control
    //////////////////////////////

    // fetch only when dispatch has room and the bus is free
    assign fetch_enable = dispatch_ok & ~data_owns_bus & ~halt_latch;

    // halted core drops whatever fetch holds
    assign fetch_flush = flush | halt_latch;

    //////////////////////////////
    // error status
    //////////////////////////////

    // illegal wins over halt
    always_comb begin
        if (illegal) begin
            error_status = illegal_inst;
        end else if (halt_latch && halt_confirm) begin
            error_status = halted_on_wfi;
        end else begin
            error_status = no_error;
        end
    end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`include "mem_port_settings.svh"

module fetch_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_enable,
    input  logic                      fetch_flush,
    input  logic                      take_branch,
    input  logic [`XLEN-1:0]          branch_target,
    input  logic [`MEM_TAG_BITS-1:0]  fetch_response,
    input  logic [`MEM_TAG_BITS-1:0]  mem_tag,
    input  mem_port_pkg::mem_block_u  mem_data,
    output logic [`XLEN-1:0]          fetch_addr,
    output logic                      fetch_valid,
    output logic [`XLEN-1:0]          fetch_pc,
    output logic [`XLEN-1:0]          fetch_inst
);

    //////////////////////////////
    // request and tag tracking
    //////////////////////////////

    logic [`XLEN-1:0]         pc;
    logic [`MEM_TAG_BITS-1:0] pending_tag;
    logic                     req_valid;
    logic                     tag_capture;
    logic                     fetch_done;
    logic                     fetch_accept;
    logic [`XLEN-1:0]         inst_word;

    // address goes out every cycle, the switch decides if it is used
    assign fetch_addr = pc;

    // one outstanding fetch at a time
    assign req_valid = fetch_enable && (pending_tag == '0);

    // only a tag for our own valid request counts
    assign tag_capture = req_valid && (fetch_response != '0);

    // matching tag on the data return
    assign fetch_done = (pending_tag != '0) && (mem_tag == pending_tag);

    // redirect or flush in the same cycle discards the reply
    assign fetch_accept = fetch_done && !take_branch && !fetch_flush;

    // pc bit 2 picks the word inside the block
    assign inst_word = mem_data.words[pc[2]];

    //////////////////////////////
    // pc, tag and valid
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc          <= `RESET_PC;
            pending_tag <= '0;
            fetch_valid <= 1'b0;
        end else begin
            // one cycle pulse per completed fetch
            fetch_valid <= fetch_accept;

            // redirect beats sequential step
            if (take_branch) begin
                pc <= branch_target;
            end else if (fetch_accept) begin
                pc <= pc + `PC_STEP;
            end

            // any of these ends the outstanding fetch
            if (take_branch || fetch_flush || fetch_accept) begin
                pending_tag <= '0;
            end else if (tag_capture) begin
                pending_tag <= fetch_response;
            end
        end
    end

    //////////////////////////////
    // fetch register payload
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (fetch_flush) begin
            fetch_pc   <= '0;
            fetch_inst <= '0;
        end else if (fetch_accept) begin
            fetch_pc   <= pc;
            fetch_inst <= inst_word;
        end
    end

endmodule

// File: src/mem_bus_switch.sv
`timescale 1ns/1ps
`include "mem_port_settings.svh"

module mem_bus_switch (
    input  logic                      data_owns_bus,
    input  logic                      route_to_data,
    input  logic                      route_to_fetch,
    input  mem_port_pkg::bus_cmd_e    dcache_command,
    input  logic [`XLEN-1:0]          dcache_addr,
    input  logic [`MEM_DWORD-1:0]     dcache_data,
    input  mem_port_pkg::mem_size_e   dcache_size,
    input  logic [`XLEN-1:0]          fetch_addr,
    input  logic [`MEM_TAG_BITS-1:0]  mem_response,
    output mem_port_pkg::bus_cmd_e    mem_command,
    output logic [`XLEN-1:0]          mem_addr,
    output logic [`MEM_DWORD-1:0]     mem_wdata,
    output mem_port_pkg::mem_size_e   mem_size,
    output logic [`MEM_TAG_BITS-1:0]  dcache_response,
    output logic [`MEM_TAG_BITS-1:0]  fetch_response
);
    import mem_port_pkg::*;

    //////////////////////////////
    // request side
    //////////////////////////////

    // data owner passes straight through
    // free bus always carries a block load for fetch
    always_comb begin
        if (data_owns_bus) begin
            mem_command = dcache_command;
            mem_addr    = dcache_addr;
            mem_wdata   = dcache_data;
            mem_size    = dcache_size;
        end else begin
            mem_command = bus_load;
            mem_addr    = fetch_addr;
            mem_wdata   = '0;
            mem_size    = size_double;
        end
    end

    //////////////////////////////
    // response side
    //////////////////////////////

    // at most one side sees the tag, often neither during a handover
    assign dcache_response = route_to_data  ? mem_response : '0;
    assign fetch_response  = route_to_fetch ? mem_response : '0;

endmodule

// File: src/mem_port_pkg.sv
`include "mem_port_settings.svh"

package mem_port_pkg;

    // memory bus command
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_e;

    // access size on the memory port
    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_e;

    // status reported from the retire side
    typedef enum logic [1:0] {
        no_error      = 2'h0,
        illegal_inst  = 2'h1,
        halted_on_wfi = 2'h2
    } error_status_e;

    // one memory block
    // data side sees a double word, fetch sees two instruction words
    // words[0] is the lower address, picked when addr bit 2 is clear
    typedef union packed {
        logic [`MEM_DWORD-1:0]       dword;
        logic [1:0][`XLEN-1:0]       words;
    } mem_block_u;

endpackage

// File: src/mem_port_settings.svh
`ifndef MEM_PORT_SETTINGS_SVH
`define MEM_PORT_SETTINGS_SVH

//////////////////////////////
// core widths
//////////////////////////////

// address and instruction width
`define XLEN 32

// one memory block, two instruction words
`define MEM_DWORD 64

// response and tag width, zero means no tag
`define MEM_TAG_BITS 4

//////////////////////////////
// fetch reset and stepping
//////////////////////////////

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// sequential fetch stride in bytes
`define PC_STEP 32'd4

`endif

// File: src/mem_port_top.sv
`timescale 1ns/1ps
`include "mem_port_settings.svh"

module mem_port_top (
    input  logic                         clock,
    input  logic                         reset,
    // memory side
    input  logic [`MEM_TAG_BITS-1:0]     mem_response,
    input  mem_port_pkg::mem_block_u     mem_data,
    input  logic [`MEM_TAG_BITS-1:0]     mem_tag,
    output mem_port_pkg::bus_cmd_e       mem_command,
    output logic [`XLEN-1:0]             mem_addr,
    output logic [`MEM_DWORD-1:0]        mem_wdata,
    output mem_port_pkg::mem_size_e      mem_size,
    // outside data cache
    input  mem_port_pkg::bus_cmd_e       dcache_command,
    input  logic [`XLEN-1:0]             dcache_addr,
    input  logic [`MEM_DWORD-1:0]        dcache_data,
    input  mem_port_pkg::mem_size_e      dcache_size,
    output logic [`MEM_TAG_BITS-1:0]     dcache_response,
    output logic [`MEM_DWORD-1:0]        dcache_rdata,
    output logic [`MEM_TAG_BITS-1:0]     dcache_rtag,
    // retire side
    input  logic                         dispatch_ok,
    input  logic                         halt,
    input  logic                         halt_confirm,
    input  logic                         illegal,
    input  logic                         flush,
    input  logic                         take_branch,
    input  logic [`XLEN-1:0]             branch_target,
    // results
    output logic                         fetch_valid,
    output logic [`XLEN-1:0]             fetch_pc,
    output logic [`XLEN-1:0]             fetch_inst,
    output logic                         if_stall,
    output mem_port_pkg::error_status_e  error_status
);

    //////////////////////////////
    // internal wires
    //////////////////////////////

    logic                     data_owns_bus;
    logic                     route_to_data;
    logic                     route_to_fetch;
    logic                     fetch_enable;
    logic                     fetch_flush;
    logic [`MEM_TAG_BITS-1:0] fetch_response;
    logic [`XLEN-1:0]         fetch_addr;

    // fetch stalls whenever data holds the bus
    assign if_stall = data_owns_bus;

    // data side reads the block as one double word
    assign dcache_rdata = mem_data.dword;
    assign dcache_rtag  = mem_tag;

    //////////////////////////////
    // instances
    //////////////////////////////

    core_mem_ctrl u_core_mem_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dcache_command (dcache_command),
        .dispatch_ok    (dispatch_ok),
        .halt           (halt),
        .halt_confirm   (halt_confirm),
        .illegal        (illegal),
        .flush          (flush),
        .data_owns_bus  (data_owns_bus),
        .route_to_data  (route_to_data),
        .route_to_fetch (route_to_fetch),
        .fetch_enable   (fetch_enable),
        .fetch_flush    (fetch_flush),
        .error_status   (error_status)
    );

    mem_bus_switch u_mem_bus_switch (
        .data_owns_bus   (data_owns_bus),
        .route_to_data   (route_to_data),
        .route_to_fetch  (route_to_fetch),
        .dcache_command  (dcache_command),
        .dcache_addr     (dcache_addr),
        .dcache_data     (dcache_data),
        .dcache_size     (dcache_size),
        .fetch_addr      (fetch_addr),
        .mem_response    (mem_response),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_size        (mem_size),
        .dcache_response (dcache_response),
        .fetch_response  (fetch_response)
    );

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .fetch_enable   (fetch_enable),
        .fetch_flush    (fetch_flush),
        .take_branch    (take_branch),
        .branch_target  (branch_target),
        .fetch_response (fetch_response),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .fetch_addr     (fetch_addr),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst)
    );

endmodule

// File: verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // reset held for five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: verification/mem_port_tb.sv
`timescale 1ns/1ps
`include "mem_port_settings.svh"

module mem_port_tb;
    import mem_port_pkg::*;

    localparam int N_TESTS = 6;
    localparam int CYCLE_LIMIT = 200 * N_TESTS;
    localparam logic [31:0] INST_KEY = 32'h1357_9bdf;

    logic clock;
    logic reset;
    logic [3:0] mem_response;
    logic [63:0] mem_data;
    logic [3:0] mem_tag;
    bus_cmd_e mem_command;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    mem_size_e mem_size;
    bus_cmd_e dcache_command;
    logic [31:0] dcache_addr;
    logic [63:0] dcache_data;
    mem_size_e dcache_size;
    logic [3:0] dcache_response;
    logic [63:0] dcache_rdata;
    logic [3:0] dcache_rtag;
    logic dispatch_ok;
    logic halt;
    logic halt_confirm;
    logic illegal;
    logic flush;
    logic take_branch;
    logic [31:0] branch_target;
    logic fetch_valid;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_inst;
    logic if_stall;
    error_status_e error_status;

    clock_gen u_clock_gen (.clock(clock), .reset(reset));

    mem_port_top u_mem_port_top (.*);

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    int          t_data_len [N_TESTS];
    logic        t_redirect [N_TESTS];
    logic [31:0] t_target   [N_TESTS];
    logic        t_halt     [N_TESTS];
    int          t_collect  [N_TESTS];

    // memory model state, three stage return pipe
    logic [3:0]  next_tag;
    logic [3:0]  pipe_tag  [3];
    logic [31:0] pipe_addr [3];

    // expected bus owner, bit 0 now and bit 2 two cycles back
    logic [2:0]  own_model;

    int          cycles;
    int          errors;
    int          got;
    logic        halted;
    logic [31:0] exp_pc;
    logic [31:0] seed;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word rule: block base, plus 4 for the upper word, then the key
    function automatic logic [31:0] inst_for(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:3], 3'b000};
        return (a[2] ? base + 32'd4 : base) ^ INST_KEY;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got_v,
                               input logic [63:0] exp_v);
        if (got_v !== exp_v) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got_v, exp_v);
            errors++;
        end
    endtask

    // one clock: port checks, memory answer, edge, return pipe, fetch monitor
    task automatic cycle_step();
        logic [31:0] base;
        logic        data_cmd;
        logic [3:0]  exp_resp;
        #1;
        // data side sees memory data and tag unchanged
        check_value("dcache_rtag", 64'(dcache_rtag), 64'(mem_tag));
        check_value("dcache_rdata", dcache_rdata, mem_data);
        // stall and port selection follow the registered owner
        check_value("if_stall", 64'(if_stall), 64'(own_model[0]));
        if (!own_model[0]) begin
            check_value("mem_command", 64'(mem_command), 64'(bus_load));
            check_value("mem_addr", 64'(mem_addr), 64'(exp_pc));
            check_value("mem_size", 64'(mem_size), 64'(size_double));
            check_value("mem_wdata", mem_wdata, 64'd0);
        end
        data_cmd = (dcache_command != bus_none);
        if (mem_command != bus_none) begin
            mem_response = next_tag;
            pipe_tag[0]  = next_tag;
            pipe_addr[0] = mem_addr;
            next_tag     = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end else begin
            mem_response = '0;
        end
        #1;
        // tag reaches the data side only when data owned the bus now and two back
        exp_resp = (own_model[0] && own_model[2]) ? mem_response : 4'd0;
        check_value("dcache_response", 64'(dcache_response), 64'(exp_resp));
        @(posedge clock);
        own_model = {own_model[1:0], data_cmd};
        #2;
        base     = {pipe_addr[2][31:3], 3'b000};
        mem_tag  = pipe_tag[2];
        mem_data = {(base + 32'd4) ^ INST_KEY, base ^ INST_KEY};
        pipe_tag[2]  = pipe_tag[1];
        pipe_addr[2] = pipe_addr[1];
        pipe_tag[1]  = pipe_tag[0];
        pipe_addr[1] = pipe_addr[0];
        pipe_tag[0]  = '0;
        mem_response = '0;
        if (fetch_valid) begin
            if (halted) begin
                $display("fetch_valid seen at %0t after the core halted", $time);
                errors++;
            end
            check_value("fetch_pc", fetch_pc, exp_pc);
            check_value("fetch_inst", fetch_inst, inst_for(exp_pc));
            exp_pc = exp_pc + 32'd4;
            got++;
        end
    endtask

    task automatic collect_fetches(input int n);
        got = 0;
        while (got < n) begin
            cycle_step();
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int err_before;
        int n_pass;
        t_data_len = '{0, 3, 0, 5, 1, 0};
        t_redirect = '{0, 0, 1, 1, 0, 0};
        t_target   = '{0, 0, 32'h0000_0100, 32'h2000_0044, 0, 0};
        t_halt     = '{0, 0, 0, 0, 0, 1};
        t_collect  = '{4, 3, 3, 3, 2, 0};
        mem_response = '0;
        mem_data = '0;
        mem_tag = '0;
        dcache_command = bus_none;
        dcache_addr = '0;
        dcache_data = '0;
        dcache_size = size_word;
        dispatch_ok = 1'b1;
        halt = 1'b0;
        halt_confirm = 1'b0;
        illegal = 1'b0;
        flush = 1'b0;
        take_branch = 1'b0;
        branch_target = '0;
        next_tag = 4'd1;
        pipe_tag = '{4'd0, 4'd0, 4'd0};
        pipe_addr = '{32'd0, 32'd0, 32'd0};
        own_model = '0;
        errors = 0;
        n_pass = 0;
        halted = 1'b0;
        exp_pc = `RESET_PC;
        seed = 32'he9d4;
        @(negedge reset);
        #2;

        // state straight out of reset
        check_value("fetch_valid", 64'(fetch_valid), 64'd0);
        check_value("if_stall", 64'(if_stall), 64'd0);
        check_value("mem_command", 64'(mem_command), 64'(bus_load));
        check_value("error_status", 64'(error_status), 64'(no_error));

        for (int t = 0; t < N_TESTS; t++) begin
            err_before = errors;
            if (t_redirect[t]) begin
                take_branch   = 1'b1;
                branch_target = t_target[t];
                cycle_step();
                exp_pc      = t_target[t];
                take_branch = 1'b0;
            end
            if (t_data_len[t] > 0) begin
                seed = xorshift(seed);
                dcache_addr    = seed;
                dcache_data    = {seed, ~seed};
                dcache_command = bus_store;
                for (int i = 0; i < t_data_len[t]; i++) begin
                    cycle_step();
                    check_value("mem_command", 64'(mem_command), 64'(bus_store));
                    check_value("mem_addr", 64'(mem_addr), 64'(seed));
                    check_value("mem_wdata", mem_wdata, {seed, ~seed});
                    check_value("mem_size", 64'(mem_size), 64'(size_word));
                    check_value("if_stall", 64'(if_stall), 64'd1);
                end
                dcache_command = bus_none;
            end
            if (t_halt[t]) begin
                halt = 1'b1;
                cycle_step();
                halt = 1'b0;
                // a fetch accepted on the halt edge may still show
                cycle_step();
                halted = 1'b1;
                check_value("error_status", 64'(error_status), 64'(no_error));
                halt_confirm = 1'b1;
                cycle_step();
                check_value("error_status", 64'(error_status), 64'(halted_on_wfi));
                illegal = 1'b1;
                cycle_step();
                check_value("error_status", 64'(error_status), 64'(illegal_inst));
                illegal = 1'b0;
                cycle_step();
                check_value("error_status", 64'(error_status), 64'(halted_on_wfi));
                repeat (20) cycle_step();
            end
            collect_fetches(t_collect[t]);
            if (errors == err_before) begin
                $display("test %0d passed", t);
                n_pass++;
            end else begin
                $display("test %0d failed with %0d errors", t, errors - err_before);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 N_TESTS, n_pass, N_TESTS - n_pass, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
